// File: design/ps2_pkg.sv
// ----------------------------------------
// ps/2 link layer definitions
// ----------------------------------------
package ps2_pkg;

	// one data byte out of a received frame
	typedef logic [7:0] scan_byte_t;

	// start + 8 data + parity + stop
	localparam int FRAME_BITS = 11;

	// ----------------------------------------
	// bytes that never map to a key
	// ----------------------------------------

	// next byte is from the extended set
	localparam scan_byte_t PREFIX_EXTENDED = 8'he0;

	// next byte is a key release
	localparam scan_byte_t PREFIX_RELEASE = 8'hf0;

	// keyboard acknowledge, passes through the prefix state untouched
	localparam scan_byte_t CODE_ACK = 8'hfa;

endpackage

// File: design/amiga_key_pkg.sv
// ----------------------------------------
// amiga side key definitions
// ----------------------------------------
package amiga_key_pkg;

	// raw amiga key code
	typedef logic [6:0] amiga_code_t;

	// key as seen by the host, top bit set on release
	typedef struct packed {
		logic        released;	// 1 = key up
		amiga_code_t code;
	} amiga_key_t;

	// one keymap lookup result
	typedef struct packed {
		logic        mapped;		// key exists in the table
		logic        is_ctrl;
		logic        is_alt_left;
		logic        is_alt_right;
		logic        is_caps;
		amiga_code_t code;
	} keymap_entry_t;

	// ----------------------------------------
	// codes with extra meaning in the filter
	// ----------------------------------------
	localparam amiga_code_t AMIGA_CAPS      = 7'h62;
	localparam amiga_code_t AMIGA_CTRL      = 7'h63;
	localparam amiga_code_t AMIGA_ALT_LEFT  = 7'h64;
	localparam amiga_code_t AMIGA_ALT_RIGHT = 7'h65;	// reset needs both alts

endpackage

// File: design/key_event_if.sv
`timescale 1ns/100ps

// decoded key event, decoder -> filter
interface key_event_if;
	import amiga_key_pkg::*;

	logic       event_valid;	// single cycle strobe
	amiga_key_t event_key;
	logic       is_ctrl;		// flags only valid with event_valid
	logic       is_alt_left;
	logic       is_alt_right;
	logic       is_caps;

	modport source (output event_valid, event_key, is_ctrl, is_alt_left, is_alt_right,
		is_caps);
	modport sink (input event_valid, event_key, is_ctrl, is_alt_left, is_alt_right,
		is_caps);

endinterface

// File: design/ps2_receiver.sv
`timescale 1ns/100ps

module ps2_receiver (
	input  logic                clk,
	input  logic                reset,
	input  logic                ps2_clk,
	input  logic                ps2_dat,
	output logic                byte_valid,
	output ps2_pkg::scan_byte_t rx_byte
);
	import ps2_pkg::*;

	logic [1:0]            clk_sync;	// [1] is the older sample
	logic [1:0]            dat_sync;
	logic                  clk_fall;
	logic [FRAME_BITS-1:0] frame;		// shifts in from the top
	logic                  frame_done;

	// both lines idle high
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			clk_sync <= '1;
			dat_sync <= '1;
		end
		else
		begin
			clk_sync <= {clk_sync[0], ps2_clk};
			dat_sync <= {dat_sync[0], ps2_dat};
		end
	end

	assign clk_fall = clk_sync[1] & ~clk_sync[0];	// keyboard drives data before this

	// start bit is the only 0 that can reach bit 0
	assign frame_done = ~frame[0];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			frame      <= '1;
			byte_valid <= 1'b0;
		end
		else
		begin
			byte_valid <= frame_done;
			if (frame_done)
				frame <= '1;	// ready for next frame
			else if (clk_fall)
				frame <= {dat_sync[1], frame[FRAME_BITS-1:1]};
		end
	end

	// data bits sit between start and parity, parity ignored
	always_ff @(posedge clk)
	begin
		if (frame_done)
			rx_byte <= frame[8:1];
	end

endmodule

// File: design/scan_decoder.sv
`timescale 1ns/100ps

module scan_decoder (
	input  logic                clk,
	input  logic                reset,
	input  logic                byte_valid,
	input  ps2_pkg::scan_byte_t rx_byte,
	key_event_if.source         events
);
	import ps2_pkg::*;
	import amiga_key_pkg::*;

	logic          extended;		// E0 seen
	logic          released;		// F0 seen
	logic          is_prefix;
	logic          lookup_strobe;	// map_q holds a fresh lookup
	logic          lookup_released;
	keymap_entry_t map_comb;
	keymap_entry_t map_q;

	// special key flags follow from the code itself
	function automatic keymap_entry_t map_key(input amiga_code_t code);
		keymap_entry_t e;
		e.mapped       = 1'b1;
		e.is_ctrl      = (code == AMIGA_CTRL);
		e.is_alt_left  = (code == AMIGA_ALT_LEFT);
		e.is_alt_right = (code == AMIGA_ALT_RIGHT);
		e.is_caps      = (code == AMIGA_CAPS);
		e.code         = code;
		return e;
	endfunction

	assign is_prefix = (rx_byte == PREFIX_EXTENDED) || (rx_byte == PREFIX_RELEASE)
		|| (rx_byte == CODE_ACK);

	// ----------------------------------------
	// prefix tracking
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			extended      <= 1'b0;
			released      <= 1'b0;
			lookup_strobe <= 1'b0;
		end
		else
		begin
			lookup_strobe <= byte_valid & ~is_prefix;
			if (byte_valid)
			begin
				if (rx_byte == PREFIX_EXTENDED)
					extended <= 1'b1;
				else if (rx_byte == PREFIX_RELEASE)
					released <= 1'b1;
				else if (rx_byte != CODE_ACK)
				begin
					extended <= 1'b0;	// key byte ends the sequence
					released <= 1'b0;
				end
			end
		end
	end

	// ----------------------------------------
	// keymap, mapped keys only
	// ----------------------------------------
	always_comb
	begin
		case ({extended, rx_byte})
			9'h001: map_comb = map_key(7'h58);	// f9
			9'h003: map_comb = map_key(7'h54);	// f5
			9'h004: map_comb = map_key(7'h52);	// f3
			9'h005: map_comb = map_key(7'h50);	// f1
			9'h006: map_comb = map_key(7'h51);	// f2
			9'h009: map_comb = map_key(7'h59);	// f10
			9'h00a: map_comb = map_key(7'h57);	// f8
			9'h00b: map_comb = map_key(7'h55);	// f6
			9'h00c: map_comb = map_key(7'h53);	// f4
			9'h00d: map_comb = map_key(7'h42);	// tab
			9'h00e: map_comb = map_key(7'h00);	// backtick
			9'h011: map_comb = map_key(AMIGA_ALT_LEFT);
			9'h012: map_comb = map_key(7'h60);	// left shift
			9'h014: map_comb = map_key(AMIGA_CTRL);
			9'h015: map_comb = map_key(7'h10);	// q
			9'h016: map_comb = map_key(7'h01);	// 1
			9'h01a: map_comb = map_key(7'h31);	// z
			9'h01b: map_comb = map_key(7'h21);	// s
			9'h01c: map_comb = map_key(7'h20);	// a
			9'h01d: map_comb = map_key(7'h11);	// w
			9'h01e: map_comb = map_key(7'h02);	// 2
			9'h021: map_comb = map_key(7'h33);	// c
			9'h022: map_comb = map_key(7'h32);	// x
			9'h023: map_comb = map_key(7'h22);	// d
			9'h024: map_comb = map_key(7'h12);	// e
			9'h025: map_comb = map_key(7'h04);	// 4
			9'h026: map_comb = map_key(7'h03);	// 3
			9'h029: map_comb = map_key(7'h40);	// space
			9'h02a: map_comb = map_key(7'h34);	// v
			9'h02b: map_comb = map_key(7'h23);	// f
			9'h02c: map_comb = map_key(7'h14);	// t
			9'h02d: map_comb = map_key(7'h13);	// r
			9'h02e: map_comb = map_key(7'h05);	// 5
			9'h031: map_comb = map_key(7'h36);	// n
			9'h032: map_comb = map_key(7'h35);	// b
			9'h033: map_comb = map_key(7'h25);	// h
			9'h034: map_comb = map_key(7'h24);	// g
			9'h035: map_comb = map_key(7'h15);	// y
			9'h036: map_comb = map_key(7'h06);	// 6
			9'h03a: map_comb = map_key(7'h37);	// m
			9'h03b: map_comb = map_key(7'h26);	// j
			9'h03c: map_comb = map_key(7'h16);	// u
			9'h03d: map_comb = map_key(7'h07);	// 7
			9'h03e: map_comb = map_key(7'h08);	// 8
			9'h041: map_comb = map_key(7'h38);	// comma
			9'h042: map_comb = map_key(7'h27);	// k
			9'h043: map_comb = map_key(7'h17);	// i
			9'h044: map_comb = map_key(7'h18);	// o
			9'h045: map_comb = map_key(7'h0a);	// 0
			9'h046: map_comb = map_key(7'h09);	// 9
			9'h049: map_comb = map_key(7'h39);	// period
			9'h04a: map_comb = map_key(7'h3a);	// slash
			9'h04b: map_comb = map_key(7'h28);	// l
			9'h04c: map_comb = map_key(7'h29);	// semicolon
			9'h04d: map_comb = map_key(7'h19);	// p
			9'h04e: map_comb = map_key(7'h0b);	// minus
			9'h052: map_comb = map_key(7'h2a);	// quote
			9'h054: map_comb = map_key(7'h1a);	// [
			9'h055: map_comb = map_key(7'h0c);	// =
			9'h058: map_comb = map_key(AMIGA_CAPS);
			9'h059: map_comb = map_key(7'h61);	// right shift
			9'h05a: map_comb = map_key(7'h44);	// return
			9'h05b: map_comb = map_key(7'h1b);	// ]
			9'h05d: map_comb = map_key(7'h0d);	// backslash
			9'h066: map_comb = map_key(7'h41);	// backspace
			9'h069: map_comb = map_key(7'h1d);	// kp 1
			9'h06b: map_comb = map_key(7'h2d);	// kp 4
			9'h06c: map_comb = map_key(7'h3d);	// kp 7
			9'h070: map_comb = map_key(7'h0f);	// kp 0
			9'h071: map_comb = map_key(7'h3c);	// kp .
			9'h072: map_comb = map_key(7'h1e);	// kp 2
			9'h073: map_comb = map_key(7'h2e);	// kp 5
			9'h074: map_comb = map_key(7'h2f);	// kp 6
			9'h075: map_comb = map_key(7'h3e);	// kp 8
			9'h076: map_comb = map_key(7'h45);	// esc
			9'h077: map_comb = map_key(7'h5a);	// num lock as kp (
			9'h078: map_comb = map_key(7'h5f);	// f11 as help
			9'h079: map_comb = map_key(7'h5e);	// kp +
			9'h07a: map_comb = map_key(7'h1f);	// kp 3
			9'h07b: map_comb = map_key(7'h4a);	// kp -
			9'h07c: map_comb = map_key(7'h5d);	// kp *
			9'h07d: map_comb = map_key(7'h3f);	// kp 9
			9'h07e: map_comb = map_key(7'h5b);	// scroll lock as kp )
			9'h083: map_comb = map_key(7'h56);	// f7
			// extended set
			9'h111: map_comb = map_key(AMIGA_ALT_RIGHT);
			9'h11f: map_comb = map_key(7'h66);	// left gui as left amiga
			9'h127: map_comb = map_key(7'h67);	// right gui as right amiga
			9'h14a: map_comb = map_key(7'h5c);	// kp /
			9'h15a: map_comb = map_key(7'h43);	// kp enter
			9'h16b: map_comb = map_key(7'h4f);	// left
			9'h171: map_comb = map_key(7'h46);	// del
			9'h172: map_comb = map_key(7'h4d);	// down
			9'h174: map_comb = map_key(7'h4e);	// right
			9'h175: map_comb = map_key(7'h4c);	// up
			default: map_comb = '0;
		endcase
	end

	// registered lookup, release flag taken before the clear
	always_ff @(posedge clk)
	begin
		if (byte_valid)
		begin
			map_q           <= map_comb;
			lookup_released <= released;
		end
	end

	assign events.event_valid  = lookup_strobe & map_q.mapped;	// unmapped keys vanish here
	assign events.event_key    = '{released: lookup_released, code: map_q.code};
	assign events.is_ctrl      = map_q.is_ctrl;
	assign events.is_alt_left  = map_q.is_alt_left;
	assign events.is_alt_right = map_q.is_alt_right;
	assign events.is_caps      = map_q.is_caps;

endmodule

// File: design/key_filter.sv
`timescale 1ns/100ps

module key_filter (
	input  logic                      clk,
	input  logic                      reset,
	key_event_if.sink                 events,
	input  logic                      flush,
	input  logic                      key_ready,
	output logic                      key_valid,
	output amiga_key_pkg::amiga_key_t key_code,
	output logic                      kbd_reset
);
	import amiga_key_pkg::*;

	amiga_key_t last_key;		// last press, or its release
	logic       caps_lock;
	logic       ctrl_up;		// held-key flags, 1 = up
	logic       alt_left_up;
	logic       alt_right_up;
	logic       same_code;
	logic       duplicate;
	logic       caps_blocked;
	logic       accept;

	// ----------------------------------------
	// typematic and caps lock filtering
	// ----------------------------------------
	assign same_code    = (last_key.code == events.event_key.code);
	assign duplicate    = same_code && (last_key.released == events.event_key.released);
	assign caps_blocked = caps_lock & events.is_caps;	// amiga keeps caps latched
	assign accept       = events.event_valid & ~duplicate & ~caps_blocked;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			last_key  <= '{released: 1'b1, code: '0};
			caps_lock <= 1'b0;
		end
		else if (events.event_valid)
		begin
			if (!events.event_key.released)
				last_key <= events.event_key;
			else if (same_code)
				last_key <= events.event_key;	// only the matching release
			if (events.is_caps && !events.event_key.released && !duplicate)
				caps_lock <= ~caps_lock;
		end
	end

	// ----------------------------------------
	// ctrl + both alts detector
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ctrl_up      <= 1'b1;
			alt_left_up  <= 1'b1;
			alt_right_up <= 1'b1;
		end
		else if (events.event_valid)
		begin
			if (events.is_ctrl)
				ctrl_up <= events.event_key.released;
			if (events.is_alt_left)
				alt_left_up <= events.event_key.released;
			if (events.is_alt_right)
				alt_right_up <= events.event_key.released;
		end
	end

	assign kbd_reset = ~(ctrl_up | alt_left_up | alt_right_up);

	// output key, new key wins over a transfer in the same cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			key_valid <= 1'b0;
		else if (accept)
			key_valid <= 1'b1;
		else if (key_ready || flush)
			key_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			key_code <= events.event_key;
	end

endmodule

// File: design/keyboard_control.sv
`timescale 1ns/100ps

module keyboard_control #(
	parameter int HOLD_TIMEOUT_CYCLES = 524288
) (
	input  logic clk,
	input  logic reset,
	input  logic key_valid,
	output logic flush,
	output logic ps2_clk_hold
);

	localparam int TIMER_W = $clog2(HOLD_TIMEOUT_CYCLES + 1);

	typedef enum logic {
		ST_RECEIVE,		// ps/2 clock released
		ST_HOLD			// key waiting for the host
	} state_t;

	state_t             state;
	logic [TIMER_W-1:0] timer;
	logic               timeout;

	// full timeout spent in hold with the key still pending
	assign timeout = (state == ST_HOLD) && key_valid
		&& (timer == TIMER_W'(HOLD_TIMEOUT_CYCLES - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_RECEIVE;
			timer <= '0;
		end
		else
		begin
			case (state)
				ST_RECEIVE:
				begin
					timer <= '0;
					if (key_valid)
						state <= ST_HOLD;
				end
				ST_HOLD:
				begin
					if (!key_valid)
					begin
						state <= ST_RECEIVE;	// host took it or flushed
						timer <= '0;
					end
					else if (timeout)
						timer <= '0;	// restart for a key loaded with the flush
					else
						timer <= timer + 1'b1;
				end
				default: state <= ST_RECEIVE;
			endcase
		end
	end

	assign flush        = timeout;
	assign ps2_clk_hold = (state == ST_HOLD);	// keyboard buffers keys meanwhile

endmodule

// File: design/ps2_keyboard.sv
`timescale 1ns/100ps

module ps2_keyboard #(
	parameter int HOLD_TIMEOUT_CYCLES = 524288
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      ps2_clk,
	input  logic                      ps2_dat,
	input  logic                      key_ready,
	output logic                      ps2_clk_hold,
	output logic                      key_valid,
	output amiga_key_pkg::amiga_key_t key_code,
	output logic                      kbd_reset
);
	import ps2_pkg::*;

	logic       byte_valid;
	scan_byte_t rx_byte;
	logic       flush;

	key_event_if u_events ();

	// ----------------------------------------
	// frame in, key event out
	// ----------------------------------------
	ps2_receiver u_ps2_receiver (
		.clk        (clk),
		.reset      (reset),
		.ps2_clk    (ps2_clk),
		.ps2_dat    (ps2_dat),
		.byte_valid (byte_valid),
		.rx_byte    (rx_byte)
	);

	scan_decoder u_scan_decoder (
		.clk        (clk),
		.reset      (reset),
		.byte_valid (byte_valid),
		.rx_byte    (rx_byte),
		.events     (u_events.source)
	);

	key_filter u_key_filter (
		.clk       (clk),
		.reset     (reset),
		.events    (u_events.sink),
		.flush     (flush),
		.key_ready (key_ready),
		.key_valid (key_valid),
		.key_code  (key_code),
		.kbd_reset (kbd_reset)
	);

	// stalls the keyboard while a key is pending
	keyboard_control #(
		.HOLD_TIMEOUT_CYCLES (HOLD_TIMEOUT_CYCLES)
	) u_keyboard_control (
		.clk          (clk),
		.reset        (reset),
		.key_valid    (key_valid),
		.flush        (flush),
		.ps2_clk_hold (ps2_clk_hold)
	);

endmodule

// File: testbench/tb_ps2_keyboard.sv
`timescale 1ns/100ps

module tb_ps2_keyboard;
	import ps2_pkg::*;
	import amiga_key_pkg::*;

	localparam int HOLD_TIMEOUT_CYCLES = 2000;	// key dropped after 16 us on hold
	localparam int CLK_NS              = 8;
	localparam int HALF_BIT_CYCLES     = 5;		// 40 ns per half bit
	localparam int BIT_NS              = 2 * HALF_BIT_CYCLES * CLK_NS;
	localparam int KEY_WAIT_CYCLES     = 20;	// well past the 5 cycle pin to key latency
	localparam int WITHHOLD_CYCLES     = 100;
	localparam int MAX_RECORDS         = 64;
	localparam     PATTERN_FILE        = "testbench/ps2_keyboard_patterns.txt";

	logic       clk;
	logic       reset;
	logic       ps2_clk;
	logic       ps2_dat;
	logic       key_ready;
	logic       ps2_clk_hold;
	logic       key_valid;
	amiga_key_t key_code;
	logic       kbd_reset;

	// one record per pattern line
	// unused byte slots stay 00
	scan_byte_t rec_bytes [0:MAX_RECORDS-1][0:2];
	int         rec_count [0:MAX_RECORDS-1];
	int         rec_expect [0:MAX_RECORDS-1];
	int         rec_key [0:MAX_RECORDS-1];
	int         rec_reset [0:MAX_RECORDS-1];
	int         rec_ready [0:MAX_RECORDS-1];	// host behavior for this key
	int         n_records;

	int         errors;
	int         checks;
	int         keys_seen;		// key_valid rising edges
	int         keys_expected;
	longint     watchdog_ns;	// 0 until the patterns are known
	logic       key_valid_q;

	ps2_keyboard #(
		.HOLD_TIMEOUT_CYCLES (HOLD_TIMEOUT_CYCLES)
	) u_ps2_keyboard (
		.clk          (clk),
		.reset        (reset),
		.ps2_clk      (ps2_clk),
		.ps2_dat      (ps2_dat),
		.key_ready    (key_ready),
		.ps2_clk_hold (ps2_clk_hold),
		.key_valid    (key_valid),
		.key_code     (key_code),
		.kbd_reset    (kbd_reset)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// ----------------------------------------
	// checking helpers
	// ----------------------------------------
	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("** Error at %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name,
				expected, actual);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("%0d ns: %s", $time, what);
	endtask

	// counts every key the DUT offers whether taken or not
	always @(negedge clk)
	begin
		if (reset)
		begin
			keys_seen   <= 0;
			key_valid_q <= 1'b0;
		end
		else
		begin
			if (key_valid && !key_valid_q)
				keys_seen <= keys_seen + 1;
			key_valid_q <= key_valid;
		end
	end

	// ----------------------------------------
	// pattern file
	// ----------------------------------------
	task automatic load_patterns();
		int               fd;
		int               fields;
		int               cnt;
		int               b0;
		int               b1;
		int               b2;
		int               want_key;
		int               key;
		int               rst;
		int               ready;
		logic [8*128-1:0] line;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0)
		begin
			report_problem("pattern file could not be opened");
			return;
		end
		while (!$feof(fd) && n_records < MAX_RECORDS)
		begin
			line = '0;
			if ($fgets(line, fd) != 0)
			begin
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h", cnt, b0, b1, b2, want_key,
					key, rst, ready);
				if (fields == 8)	// comments and blank lines give no fields
				begin
					if (cnt < 1 || cnt > 3)
						report_problem($sformatf("pattern record %0d has a bad byte count",
							n_records));
					rec_count[n_records]    = cnt;
					rec_bytes[n_records][0] = b0[7:0];
					rec_bytes[n_records][1] = b1[7:0];
					rec_bytes[n_records][2] = b2[7:0];
					rec_expect[n_records]   = want_key;
					rec_key[n_records]      = key;
					rec_reset[n_records]    = rst;
					rec_ready[n_records]    = ready;
					n_records++;
				end
			end
		end
		$fclose(fd);
		if (n_records == 0)
			report_problem("no pattern records found");
	endtask

	// ----------------------------------------
	// keyboard and host models
	// ----------------------------------------
	task automatic send_byte(input scan_byte_t data);
		logic [FRAME_BITS-1:0] frame;
		int                    i;
		frame = {1'b1, ~^data, data, 1'b0};	// stop, odd parity, data, start
		while (ps2_clk_hold)
			@(negedge clk);	// keyboard buffers while clock is held low
		for (i = 0; i < FRAME_BITS; i++)
		begin
			ps2_dat = frame[i];	// data settles while clock is high
			repeat (HALF_BIT_CYCLES) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (HALF_BIT_CYCLES) @(negedge clk);
			ps2_clk = 1'b1;
		end
		ps2_dat = 1'b1;
		repeat (2 * HALF_BIT_CYCLES) @(negedge clk);	// idle gap between frames
	endtask

	task automatic take_key(input int delay);
		repeat (delay) @(negedge clk);
		key_ready = 1'b1;
		@(negedge clk);
		key_ready = 1'b0;
		check("key_valid", 0, key_valid);	// transfer ends on the edge in between
	endtask

	// ----------------------------------------
	// one record from bytes in to key out
	// ----------------------------------------
	task automatic run_record(input int r);
		int i;
		int waited;
		for (i = 0; i < rec_count[r]; i++)
			send_byte(rec_bytes[r][i]);
		waited = 0;
		while (!key_valid && waited < KEY_WAIT_CYCLES)
		begin
			@(negedge clk);
			waited++;
		end
		if (rec_expect[r] != 0)
			keys_expected++;
		if (!key_valid)
		begin
			if (rec_expect[r] != 0)
				report_problem($sformatf("record %0d: expected key 0x%02h never arrived", r,
					rec_key[r]));
		end
		else if (rec_expect[r] == 0)
		begin
			report_problem($sformatf("record %0d: unexpected key 0x%02h", r, key_code));
			take_key(0);
		end
		else
		begin
			check("key_code", rec_key[r], key_code);
			case (rec_ready[r])
				1:
				begin
					repeat (WITHHOLD_CYCLES) @(negedge clk);
					check("ps2_clk_hold", 1, ps2_clk_hold);	// keyboard stalled
					check("key_valid", 1, key_valid);	// key still offered
					take_key(0);
				end
				2:
				begin
					waited = 0;
					while (key_valid && waited < HOLD_TIMEOUT_CYCLES + KEY_WAIT_CYCLES)
					begin
						@(negedge clk);
						waited++;
					end
					if (key_valid)
						report_problem($sformatf("record %0d: key not dropped after hold timeout",
							r));
					else if (waited < HOLD_TIMEOUT_CYCLES - KEY_WAIT_CYCLES)
						report_problem($sformatf("record %0d: key dropped before hold timeout",
							r));
				end
				default: take_key(int'($urandom % 8));	// host answers in 0 to 7 cycles
			endcase
		end
		check("kbd_reset", rec_reset[r], kbd_reset);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin : stimulus
		int r;
		int total_bytes;
		int timeouts;
		clk         = 1'b0;
		reset       = 1'b1;
		ps2_clk     = 1'b1;	// both lines idle high
		ps2_dat     = 1'b1;
		key_ready   = 1'b0;
		total_bytes = 0;
		timeouts    = 0;
		void'($urandom(32'h6274));
		load_patterns();
		for (r = 0; r < n_records; r++)
		begin
			total_bytes += rec_count[r];
			if (rec_ready[r] == 2)
				timeouts++;
		end
		watchdog_ns = 2 * (longint'(total_bytes) * FRAME_BITS * BIT_NS
			+ longint'(timeouts) * HOLD_TIMEOUT_CYCLES * CLK_NS);
		repeat (10) @(negedge clk);
		reset = 1'b0;
		check("key_valid", 0, key_valid);
		check("ps2_clk_hold", 0, ps2_clk_hold);
		check("kbd_reset", 0, kbd_reset);	// all three keys start up
		for (r = 0; r < n_records; r++)
			run_record(r);
		repeat (KEY_WAIT_CYCLES) @(negedge clk);
		check("key_valid", 0, key_valid);	// nothing left over
		check("keys seen", keys_expected, keys_seen);
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// limit from frame count and hold timeouts
	initial
	begin : watchdog
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, stimulus did not finish", watchdog_ns);
		$display("checks: %0d  errors: %0d", checks, errors + 1);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: testbench/ps2_keyboard_patterns.txt
# count byte0 byte1 byte2 key_expected key_code kbd_reset ready_mode (all hex)
# ready_mode 0 random delay, 1 withheld a while, 2 withheld past the hold timeout
# mapping
1 1c 00 00 1 20 0 0
2 f0 1c 00 1 a0 0 0
2 e0 75 00 1 4c 0 0
3 e0 f0 75 1 cc 0 0
1 76 00 00 1 45 0 0
2 e0 71 00 1 46 0 0
3 e0 f0 71 1 c6 0 0
2 f0 76 00 1 c5 0 0
# typematic
1 1b 00 00 1 21 0 0
1 1b 00 00 0 00 0 0
1 23 00 00 1 22 0 0
1 1b 00 00 1 21 0 0
2 f0 1b 00 1 a1 0 0
2 f0 23 00 1 a2 0 0
# caps lock
1 58 00 00 1 62 0 0
2 f0 58 00 0 00 0 0
1 58 00 00 0 00 0 0
2 f0 58 00 1 e2 0 0
1 58 00 00 1 62 0 0
1 58 00 00 0 00 0 0
2 f0 58 00 0 00 0 0
# ctrl and both alts
1 14 00 00 1 63 0 0
1 11 00 00 1 64 0 0
2 e0 11 00 1 65 1 0
2 e0 11 00 0 00 1 0
2 f0 14 00 1 e3 0 0
1 14 00 00 1 63 1 0
2 f0 11 00 1 e4 0 0
3 e0 f0 11 1 e5 0 0
2 f0 14 00 1 e3 0 0
2 f0 14 00 0 00 0 0
# back-pressure
1 15 00 00 1 10 0 1
1 16 00 00 1 01 0 0
1 1d 00 00 1 11 0 2
2 f0 16 00 1 81 0 0
2 f0 1d 00 1 91 0 0
2 f0 15 00 1 90 0 0
# ignored codes
1 fa 00 00 0 00 0 0
1 07 00 00 0 00 0 0
2 e0 7c 00 0 00 0 0
1 0f 00 00 0 00 0 0
3 e0 fa 6b 1 4f 0 0
3 e0 f0 6b 1 cf 0 0

// File: build.f
design/ps2_pkg.sv
design/amiga_key_pkg.sv
design/key_event_if.sv
design/ps2_receiver.sv
design/scan_decoder.sv
design/key_filter.sv
design/keyboard_control.sv
design/ps2_keyboard.sv
testbench/tb_ps2_keyboard.sv

// File: run.sh
#!/bin/sh
# build and run the ps2 keyboard regression with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f \
	--top-module tb_ps2_keyboard -o sim_tb_ps2_keyboard

out=$(obj_dir/sim_tb_ps2_keyboard)
printf '%s\n' "$out"

# exit status follows the pass line
printf '%s\n' "$out" | grep -q "Regression passed"
